// ==== hdl/spi_cmd_pkg.sv ====
package spi_cmd_pkg;

  // Command word layout
  localparam int CMD_WIDTH    = 12;
  localparam int READ_WIDTH   = 8;
  localparam int RW_BIT       = 11; // 1 selects a write
  localparam int ADDR_MSB     = 10;
  localparam int ADDR_LSB     = 8;
  localparam int RD_ADDR_BITS = 4;  // Type flag plus the address

  // Serial timing in clk cycles
  localparam int SCLK_HALF       = 4;
  localparam int READ_GAP_CYCLES = 100;

  // Counter widths
  localparam int BIT_CNT_WIDTH  = 4;
  localparam int GAP_CNT_WIDTH  = 7;
  localparam int HALF_CNT_WIDTH = $clog2(SCLK_HALF);

  // Frame shifter states
  localparam int STATE_WIDTH = 3;
  localparam logic [STATE_WIDTH-1:0] ST_IDLE    = 3'd0;
  localparam logic [STATE_WIDTH-1:0] ST_WRITE   = 3'd1;
  localparam logic [STATE_WIDTH-1:0] ST_RD_ADDR = 3'd2;
  localparam logic [STATE_WIDTH-1:0] ST_RD_GAP  = 3'd3;
  localparam logic [STATE_WIDTH-1:0] ST_RD_DATA = 3'd4;
  localparam logic [STATE_WIDTH-1:0] ST_DONE    = 3'd5;

endpackage

// ==== hdl/spi_cmd_stage.sv ====
`timescale 1ns/1ns

module spi_cmd_stage
  import spi_cmd_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [CMD_WIDTH-1:0] cmd_in,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  input  logic                 busy,
  output logic                 frame_start,
  output logic [CMD_WIDTH-1:0] frame_cmd
);

  logic [CMD_WIDTH-1:0] slot_q;
  logic                 full_q;
  logic                 accept;

  // The slot takes a new word only when it is empty
  assign cmd_rdy = !full_q;
  assign accept  = cmd_vld && cmd_rdy;

  // A held command goes out as soon as the shifter is idle
  assign frame_start = full_q && !busy;

  // The shifter copies this word on frame_start, so a new command may refill the slot
  // while the previous frame is still being shifted
  assign frame_cmd = slot_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      full_q <= 1'b0;
    end
    else if (accept)
    begin
      full_q <= 1'b1;
    end
    else if (frame_start)
    begin
      full_q <= 1'b0; // Slot frees on the cycle after launch
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      slot_q <= cmd_in;
    end
  end

endmodule

// ==== hdl/spi_sclk_gen.sv ====
`timescale 1ns/1ns

module spi_sclk_gen
  import spi_cmd_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic sclk_en,
  output logic sclk_level,
  output logic sclk_rise,
  output logic sclk_fall
);

  logic [HALF_CNT_WIDTH-1:0] half_cnt;
  logic                      sclk_q;
  logic                      toggle;

  // Toggle happens on the clk edge that closes the last cycle of a half period
  assign toggle = sclk_en && (half_cnt == HALF_CNT_WIDTH'(SCLK_HALF - 1));

  assign sclk_rise = toggle && !sclk_q;
  assign sclk_fall = toggle && sclk_q;

  // Dropping the enable pulls the pin low in the same cycle
  assign sclk_level = sclk_q && sclk_en;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      half_cnt <= '0;
      sclk_q   <= 1'b0;
    end
    else if (!sclk_en)
    begin
      half_cnt <= '0;
      sclk_q   <= 1'b0;
    end
    else if (toggle)
    begin
      half_cnt <= '0;
      sclk_q   <= !sclk_q;
    end
    else
    begin
      half_cnt <= half_cnt + 1'b1;
    end
  end

endmodule

// ==== hdl/spi_frame_shifter.sv ====
`timescale 1ns/1ns

module spi_frame_shifter
  import spi_cmd_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  frame_start,
  input  logic [CMD_WIDTH-1:0]  frame_cmd,
  output logic                  busy,
  output logic                  sclk_en,
  input  logic                  sclk_rise,
  input  logic                  sclk_fall,
  output logic                  cs_n,
  output logic                  mosi,
  input  logic                  miso,
  output logic                  read_vld,
  output logic [READ_WIDTH-1:0] read_data
);

  logic [STATE_WIDTH-1:0]   state;
  logic [CMD_WIDTH-1:0]     tx_load;
  logic [CMD_WIDTH-1:0]     tx_shift;
  logic [READ_WIDTH-1:0]    rx_shift;
  logic [BIT_CNT_WIDTH-1:0] bit_cnt;
  logic [BIT_CNT_WIDTH-1:0] last_tx_bit;
  logic [GAP_CNT_WIDTH-1:0] gap_cnt;
  logic                     mosi_q;
  logic                     launch;

  assign launch = (state == ST_IDLE) && frame_start;

  // A read only sends the type flag and the address, so that field is moved down to bit 0
  assign tx_load = frame_cmd[RW_BIT] ? frame_cmd :
                   CMD_WIDTH'({frame_cmd[RW_BIT], frame_cmd[ADDR_MSB:ADDR_LSB]});

  assign last_tx_bit = (state == ST_WRITE) ? BIT_CNT_WIDTH'(CMD_WIDTH - 1) :
                                             BIT_CNT_WIDTH'(RD_ADDR_BITS - 1);

  // Chip select is low exactly while the serial clock runs
  assign sclk_en = (state == ST_WRITE) || (state == ST_RD_ADDR) ||
                   (state == ST_RD_DATA) || (state == ST_DONE);
  assign cs_n    = !sclk_en;

  assign busy      = (state != ST_IDLE);
  assign mosi      = mosi_q;
  assign read_vld  = (state == ST_DONE);
  assign read_data = rx_shift;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= ST_IDLE;
      bit_cnt <= '0;
      gap_cnt <= '0;
      mosi_q  <= 1'b0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (frame_start)
          begin
            state   <= frame_cmd[RW_BIT] ? ST_WRITE : ST_RD_ADDR;
            bit_cnt <= '0;
            mosi_q  <= tx_load[0]; // First bit is on the pin as cs_n falls
          end
        end
        ST_WRITE, ST_RD_ADDR:
        begin
          if (sclk_fall)
          begin
            if (bit_cnt == last_tx_bit)
            begin
              state   <= (state == ST_WRITE) ? ST_IDLE : ST_RD_GAP;
              bit_cnt <= '0;
              gap_cnt <= '0;
              mosi_q  <= 1'b0;
            end
            else
            begin
              bit_cnt <= bit_cnt + 1'b1;
              mosi_q  <= tx_shift[0];
            end
          end
        end
        ST_RD_GAP:
        begin
          if (gap_cnt == GAP_CNT_WIDTH'(READ_GAP_CYCLES - 1))
          begin
            state <= ST_RD_DATA;
          end
          else
          begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        ST_RD_DATA:
        begin
          if (sclk_rise)
          begin
            if (bit_cnt == BIT_CNT_WIDTH'(READ_WIDTH - 1))
            begin
              state <= ST_DONE; // Last sample taken
            end
            else
            begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        ST_DONE:
        begin
          state <= ST_IDLE;
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Transmit bits leave LSB first and received bits enter MSB first
  always_ff @(posedge clk)
  begin
    if (launch)
    begin
      tx_shift <= tx_load >> 1;
    end
    else if (sclk_fall)
    begin
      tx_shift <= tx_shift >> 1;
    end
    if ((state == ST_RD_DATA) && sclk_rise)
    begin
      rx_shift <= {rx_shift[READ_WIDTH-2:0], miso};
    end
  end

endmodule

// ==== hdl/spi_cmd_master.sv ====
`timescale 1ns/1ns

module spi_cmd_master
  import spi_cmd_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [CMD_WIDTH-1:0]  cmd_in,
  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  output logic                  sclk,
  output logic                  cs_n,
  output logic                  mosi,
  input  logic                  miso,
  output logic                  read_vld,
  output logic [READ_WIDTH-1:0] read_data
);

  logic                 frame_start;
  logic [CMD_WIDTH-1:0] frame_cmd;
  logic                 busy;
  logic                 sclk_en;
  logic                 sclk_rise;
  logic                 sclk_fall;

  spi_cmd_stage u_cmd_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_in      (cmd_in),
    .cmd_vld     (cmd_vld),
    .cmd_rdy     (cmd_rdy),
    .busy        (busy),
    .frame_start (frame_start),
    .frame_cmd   (frame_cmd)
  );

  spi_sclk_gen u_sclk_gen (
    .clk        (clk),
    .rst_n      (rst_n),
    .sclk_en    (sclk_en),
    .sclk_level (sclk),
    .sclk_rise  (sclk_rise),
    .sclk_fall  (sclk_fall)
  );

  spi_frame_shifter u_frame_shifter (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame_start (frame_start),
    .frame_cmd   (frame_cmd),
    .busy        (busy),
    .sclk_en     (sclk_en),
    .sclk_rise   (sclk_rise),
    .sclk_fall   (sclk_fall),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .miso        (miso),
    .read_vld    (read_vld),
    .read_data   (read_data)
  );

endmodule

// ==== dv/spi_cmd_master_asserts.sv ====
`timescale 1ns/1ns

module spi_cmd_master_asserts (
  input logic clk,
  input logic rst_n,
  input logic sclk,
  input logic cs_n,
  input logic mosi,
  input logic cmd_rdy,
  input logic read_vld
);

  // The serial clock only runs inside a frame
  sclk_idle_low: assert property (@(posedge clk) disable iff (!rst_n) cs_n |-> !sclk)
    else $error("sclk high while cs_n is high");

  // Mode 0 puts new data on mosi only while sclk is low
  mosi_stable: assert property (@(posedge clk) disable iff (!rst_n)
    sclk |-> $stable(mosi))
    else $error("mosi changed while sclk was high");

  ready_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> cmd_rdy)
    else $error("cmd_rdy low in the first cycle after reset");

  read_vld_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |=> !read_vld)
    else $error("read_vld lasted longer than one cycle");

endmodule

// ==== dv/spi_cmd_master_tb.sv ====
`timescale 1ns/1ns

module spi_cmd_master_tb
  import spi_cmd_pkg::*;
;

  localparam int NUM_CMDS   = 80;
  localparam int MAX_CYCLES = NUM_CMDS * (112 + READ_GAP_CYCLES + 16) + 2000;
  localparam int WRITE_LOW  = CMD_WIDTH * 2 * SCLK_HALF;

  logic                  clk;
  logic                  rst_n;
  logic [CMD_WIDTH-1:0]  cmd_in;
  logic                  cmd_vld;
  logic                  cmd_rdy;
  logic                  sclk;
  logic                  cs_n;
  logic                  mosi;
  logic                  miso;
  logic                  read_vld;
  logic [READ_WIDTH-1:0] read_data;

  integer seed = 32'ha5de_1b2b;
  int     errors = 0;
  int     checks = 0;
  int     tests = 0;
  int     cycles = 0;
  int     n_acc = 0;     // Commands taken by the DUT
  int     n_started = 0; // Frames whose first cs_n fall was seen
  int     n_done = 0;    // Frames fully finished

  logic [READ_WIDTH-1:0] ref_mem [8];   // Reference register file
  logic [READ_WIDTH-1:0] slave_mem [8]; // Registers inside the SPI slave
  logic [CMD_WIDTH-1:0]  exp_frames [$];
  logic [READ_WIDTH-1:0] exp_reads [$];

  // Slave decoder state
  logic [15:0] rx_bits;
  int          rx_cnt;
  int          low_cycles;
  int          gap_cycles;
  logic        in_gap = 1'b0;
  logic        data_phase = 1'b0;
  logic [2:0]  rd_addr;
  int          rd_idx;

  spi_cmd_master dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  bind spi_cmd_master spi_cmd_master_asserts u_asserts (
    .clk      (clk),
    .rst_n    (rst_n),
    .sclk     (sclk),
    .cs_n     (cs_n),
    .mosi     (mosi),
    .cmd_rdy  (cmd_rdy),
    .read_vld (read_vld)
  );

  initial
  begin
    clk = 1'b0;
  end

  always #50 clk = !clk;

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout: DUT did not finish the commands within %0d cycles", MAX_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic check_cmd(input string name, input logic [CMD_WIDTH-1:0] got,
                           input logic [CMD_WIDTH-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error %s got 0x%03h expected 0x%03h", name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input logic [READ_WIDTH-1:0] got,
                            input logic [READ_WIDTH-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error %s got 0x%02h expected 0x%02h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic fail_msg(input string what);
    errors++;
    $display("%s", what);
  endtask

  // The slave takes a 12 bit frame as a write and a 4 bit one as the start of a read
  always @(negedge cs_n)
  begin
    if (in_gap)
    begin
      in_gap = 1'b0;
      data_phase = 1'b1;
      if (gap_cycles != READ_GAP_CYCLES)
      begin
        fail_msg($sformatf("read gap lasted %0d cycles instead of %0d",
                           gap_cycles, READ_GAP_CYCLES));
      end
      rd_idx = 0;
      miso = slave_mem[rd_addr][READ_WIDTH-1];
    end
    else
    begin
      n_started++;
      rx_bits = '0;
      rx_cnt = 0;
      low_cycles = 0;
    end
  end

  always @(posedge sclk)
  begin
    if (!cs_n && !data_phase && rx_cnt < 16)
    begin
      rx_bits[rx_cnt] = mosi; // Command bits arrive LSB first
      rx_cnt++;
    end
  end

  always @(negedge sclk)
  begin
    if (data_phase && rd_idx < READ_WIDTH - 1)
    begin
      rd_idx++;
      miso = slave_mem[rd_addr][READ_WIDTH-1-rd_idx];
    end
  end

  always @(posedge cs_n)
  begin
    logic [CMD_WIDTH-1:0] exp;
    if (!rst_n || data_phase) // cs_n also rises when reset first drives it
    begin
      data_phase = 1'b0;
    end
    else if (exp_frames.size() == 0)
    begin
      fail_msg("frame seen on the SPI pins without an accepted command");
    end
    else
    begin
      exp = exp_frames.pop_front();
      if (rx_cnt == CMD_WIDTH)
      begin
        check_bit("frame_is_write", exp[RW_BIT], 1'b1);
        check_cmd("mosi_frame", rx_bits[CMD_WIDTH-1:0], exp);
        if (low_cycles != WRITE_LOW)
        begin
          fail_msg($sformatf("cs_n was low %0d cycles in a write, expected %0d",
                             low_cycles, WRITE_LOW));
        end
        slave_mem[rx_bits[ADDR_MSB:ADDR_LSB]] = rx_bits[READ_WIDTH-1:0];
        n_done++;
      end
      else if (rx_cnt == RD_ADDR_BITS)
      begin
        check_bit("frame_is_write", exp[RW_BIT], 1'b0);
        check_cmd("mosi_addr", CMD_WIDTH'(rx_bits[RD_ADDR_BITS-1:0]),
                  CMD_WIDTH'(exp[CMD_WIDTH-1:ADDR_LSB]));
        rd_addr = rx_bits[2:0];
        gap_cycles = 0;
        in_gap = 1'b1;
      end
      else
      begin
        fail_msg($sformatf("frame with %0d bits, neither a write nor a read", rx_cnt));
      end
    end
  end

  always @(negedge clk)
  begin
    if (!cs_n && !data_phase)
    begin
      low_cycles++;
    end
    if (in_gap && cs_n)
    begin
      gap_cycles++;
    end
    if (read_vld)
    begin
      if (exp_reads.size() == 0)
      begin
        fail_msg("read_vld pulse without a pending read");
      end
      else
      begin
        check_data("read_data", read_data, exp_reads.pop_front());
      end
      n_done++;
    end
  end

  function automatic logic [CMD_WIDTH-1:0] rand_cmd(input logic is_write);
    logic [31:0]          r;
    logic [CMD_WIDTH-1:0] c;
    r = $random(seed);
    c = r[CMD_WIDTH-1:0];
    c[RW_BIT] = is_write;
    return c;
  endfunction

  // Holds cmd_vld until the DUT takes the word, updating the reference on acceptance
  task automatic send_cmd(input logic [CMD_WIDTH-1:0] c);
    logic taken;
    taken = 1'b0;
    @(negedge clk);
    cmd_in = c;
    cmd_vld = 1'b1;
    while (!taken)
    begin
      check_bit("cmd_rdy", cmd_rdy, (n_acc == n_started));
      if (cmd_rdy)
      begin
        taken = 1'b1;
        n_acc++;
        exp_frames.push_back(c);
        if (c[RW_BIT])
        begin
          ref_mem[c[ADDR_MSB:ADDR_LSB]] = c[READ_WIDTH-1:0];
        end
        else
        begin
          exp_reads.push_back(ref_mem[c[ADDR_MSB:ADDR_LSB]]);
        end
      end
      else
      begin
        @(negedge clk);
      end
    end
  endtask

  task automatic release_cmd();
    @(negedge clk);
    cmd_vld = 1'b0;
  endtask

  task automatic wait_idle();
    while (n_done < n_acc || !cs_n)
    begin
      @(negedge clk);
    end
  endtask

  task automatic report(input string name, input int err_before);
    tests++;
    if (n_done != n_acc)
    begin
      fail_msg($sformatf("%0d frames finished for %0d accepted commands", n_done, n_acc));
    end
    $display("test %-14s %s", name, (errors == err_before) ? "ok" : "with errors");
  endtask

  initial
  begin
    int e;
    int gap;
    logic [31:0] r;
    for (int a = 0; a < 8; a++)
    begin
      ref_mem[a] = 8'(a * 8'h1d) ^ 8'h5a; // Fill depends on every address bit
      slave_mem[a] = ref_mem[a];
    end
    rst_n = 1'b0;
    cmd_in = '0;
    cmd_vld = 1'b0;
    miso = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    e = errors;
    @(negedge clk);
    check_bit("cs_n", cs_n, 1'b1);
    check_bit("sclk", sclk, 1'b0);
    check_bit("mosi", mosi, 1'b0);
    check_bit("cmd_rdy", cmd_rdy, 1'b1);
    check_bit("read_vld", read_vld, 1'b0);
    report("reset_state", e);

    e = errors;
    for (int i = 0; i < 8; i++)
    begin
      send_cmd(rand_cmd(1'b1));
      release_cmd();
      wait_idle();
    end
    report("write_frame", e);

    e = errors;
    for (int i = 0; i < 6; i++)
    begin
      send_cmd(rand_cmd(1'b0));
      release_cmd();
      wait_idle();
    end
    report("read_gap", e);

    e = errors;
    for (int i = 0; i < 8; i++)
    begin
      send_cmd(rand_cmd(1'b1));
    end
    for (int i = 0; i < 8; i++)
    begin
      send_cmd(rand_cmd(1'b0));
    end
    release_cmd();
    wait_idle();
    report("write_readback", e);

    e = errors;
    for (int i = 0; i < 10; i++)
    begin
      r = $random(seed);
      send_cmd(rand_cmd(r[0]));
    end
    release_cmd();
    wait_idle();
    report("back_pressure", e);

    e = errors;
    for (int i = 0; i < 40; i++)
    begin
      r = $random(seed);
      send_cmd(rand_cmd(r[0]));
      gap = int'(r[8:4]) % 21;
      if (gap > 0)
      begin
        release_cmd();
        repeat (gap) @(negedge clk);
      end
    end
    release_cmd();
    wait_idle();
    report("random_mix", e);

    $display("tests %0d, checks %0d, commands %0d, errors %0d", tests, checks, n_acc, errors);
    if (errors == 0)
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
hdl/spi_cmd_pkg.sv
hdl/spi_cmd_stage.sv
hdl/spi_sclk_gen.sv
hdl/spi_frame_shifter.sv
hdl/spi_cmd_master.sv
dv/spi_cmd_master_asserts.sv
dv/spi_cmd_master_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= spi_cmd_master_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= *** PASSED ***

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
